// ==== source/idremap_consts.svh ====
// AXI ID remapper constants
`ifndef IDREMAP_CONSTS_SVH
`define IDREMAP_CONSTS_SVH

// Upstream and downstream ID widths
`define ID_IN_WIDTH 4
`define ID_OUT_WIDTH 3

// Output IDs per direction, also the burst limit of one entry
`define TABLE_SIZE 4
`define IDX_WIDTH 2

// Wide enough to hold TABLE_SIZE itself
`define CNT_WIDTH 3

// Request and data payload widths
`define ADDR_WIDTH 16
`define DATA_WIDTH 32

`endif

// ==== source/axi_chan_pkg.sv ====
// AXI channel payload types
`default_nettype none
`include "idremap_consts.svh"

package axi_chan_pkg;

  typedef logic [`ID_IN_WIDTH-1:0] id_in_t;
  typedef logic [`ID_OUT_WIDTH-1:0] id_out_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Request fields that are forwarded untouched on AW and AR
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] addr;
    logic [7:0]             len;
  } ax_payload_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0]   data;
    logic [`DATA_WIDTH/8-1:0] strb;
    logic                     last;
  } w_beat_t;

  typedef struct packed {
    resp_e resp;
  } b_payload_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    resp_e                  resp;
    logic                   last;
  } r_beat_t;

endpackage

`default_nettype wire

// ==== source/remap_pkg.sv ====
// Remap table and controller types
`default_nettype none
`include "idremap_consts.svh"

package remap_pkg;

  typedef logic [`IDX_WIDTH-1:0] idx_t;
  typedef logic [`CNT_WIDTH-1:0] cnt_t;

  // One entry per output ID
  typedef struct packed {
    axi_chan_pkg::id_in_t inp_id;
    cnt_t                 cnt;
  } table_entry_t;

  typedef enum logic [1:0] {
    READY,
    HOLD_AR,
    HOLD_AW,
    HOLD_AX
  } remap_state_e;

  // Lowest set bit wins, an all-zero vector gives index zero
  function automatic idx_t lowest_index(input logic [`TABLE_SIZE-1:0] vec);
    idx_t idx;
    idx = '0;
    for (int i = `TABLE_SIZE - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

// ==== source/remap_table.sv ====
// ID remap table
`timescale 1ns/10ps
`default_nettype none
`include "idremap_consts.svh"

module remap_table (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire axi_chan_pkg::id_in_t lookup_id_i,
  input  wire logic                 push_i,
  input  wire remap_pkg::idx_t      push_idx_i,
  input  wire axi_chan_pkg::id_in_t push_id_i,
  input  wire logic                 pop_i,
  input  wire remap_pkg::idx_t      pop_idx_i,
  output remap_pkg::idx_t           free_o,
  output logic                      full_o,
  output logic                      exists_o,
  output remap_pkg::idx_t           exists_idx_o,
  output logic                      exists_full_o,
  output axi_chan_pkg::id_in_t      pop_id_o
);

  remap_pkg::table_entry_t table_q [`TABLE_SIZE];
  remap_pkg::table_entry_t table_d [`TABLE_SIZE];

  logic [`TABLE_SIZE-1:0] free_vec;
  logic [`TABLE_SIZE-1:0] match_vec;

  // An entry is free when nothing is in flight on its output ID
  always_comb begin
    for (int i = 0; i < `TABLE_SIZE; i++) begin
      free_vec[i]  = (table_q[i].cnt == '0);
      match_vec[i] = (table_q[i].cnt != '0) && (table_q[i].inp_id == lookup_id_i);
    end
  end

  assign free_o        = remap_pkg::lowest_index(free_vec);
  assign full_o        = ~|free_vec;
  assign exists_o      = |match_vec;
  assign exists_idx_o  = remap_pkg::lowest_index(match_vec);
  assign exists_full_o = (table_q[exists_idx_o].cnt == remap_pkg::cnt_t'(`TABLE_SIZE));

  // Responses look up the input ID that owns their output ID
  assign pop_id_o = table_q[pop_idx_i].inp_id;

  // Push and pop may hit the same entry in one cycle and then cancel out
  always_comb begin
    for (int i = 0; i < `TABLE_SIZE; i++) begin
      table_d[i] = table_q[i];
    end
    if (push_i) begin
      table_d[push_idx_i].inp_id = push_id_i;
      table_d[push_idx_i].cnt    = table_d[push_idx_i].cnt + remap_pkg::cnt_t'(1);
    end
    if (pop_i) begin
      table_d[pop_idx_i].cnt = table_d[pop_idx_i].cnt - remap_pkg::cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `TABLE_SIZE; i++) begin
        table_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `TABLE_SIZE; i++) begin
        table_q[i] <= table_d[i];
      end
    end
  end

  // The controller must only reuse an entry that belongs to the same input ID
  a_push_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> (table_q[push_idx_i].cnt == '0) ||
                 (table_q[push_idx_i].inp_id == push_id_i))
    else $error("push to an entry owned by another input ID");

  a_push_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> table_q[push_idx_i].cnt < remap_pkg::cnt_t'(`TABLE_SIZE))
    else $error("push beyond the in-flight limit of an entry");

  // A response on an idle output ID means the downstream side is broken
  a_pop_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pop_i |-> table_q[pop_idx_i].cnt != '0)
    else $error("pop on an entry with nothing in flight");

  a_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(match_vec))
    else $error("input ID held by more than one entry");

endmodule

`default_nettype wire

// ==== source/id_remap_ctrl.sv ====
// ID remap request controller
`timescale 1ns/10ps
`default_nettype none

module id_remap_ctrl (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 aw_valid_i,
  input  wire axi_chan_pkg::id_in_t aw_id_i,
  input  wire logic                 ar_valid_i,
  input  wire axi_chan_pkg::id_in_t ar_id_i,
  input  wire logic                 m_aw_ready_i,
  input  wire logic                 m_ar_ready_i,
  input  wire remap_pkg::idx_t      wr_free_i,
  input  wire logic                 wr_full_i,
  input  wire logic                 wr_exists_i,
  input  wire remap_pkg::idx_t      wr_exists_idx_i,
  input  wire logic                 wr_exists_full_i,
  input  wire remap_pkg::idx_t      rd_free_i,
  input  wire logic                 rd_full_i,
  input  wire logic                 rd_exists_i,
  input  wire remap_pkg::idx_t      rd_exists_idx_i,
  input  wire logic                 rd_exists_full_i,
  output logic                      aw_ready_o,
  output logic                      ar_ready_o,
  output logic                      m_aw_valid_o,
  output logic                      m_ar_valid_o,
  output axi_chan_pkg::id_out_t     m_aw_id_o,
  output axi_chan_pkg::id_out_t     m_ar_id_o,
  output logic                      wr_push_o,
  output remap_pkg::idx_t           wr_push_idx_o,
  output logic                      rd_push_o,
  output remap_pkg::idx_t           rd_push_idx_o
);

  remap_pkg::remap_state_e state_q, state_d;
  remap_pkg::idx_t         aw_idx_q, aw_idx_d, aw_idx;
  remap_pkg::idx_t         ar_idx_q, ar_idx_d, ar_idx;
  logic                    aw_ok, ar_ok;

  // Room exists either in the matching entry or in a free one
  assign aw_ok = wr_exists_i ? !wr_exists_full_i : !wr_full_i;
  assign ar_ok = rd_exists_i ? !rd_exists_full_i : !rd_full_i;

  always_comb begin
    state_d      = state_q;
    aw_idx_d     = aw_idx_q;
    ar_idx_d     = ar_idx_q;
    aw_idx       = aw_idx_q;
    ar_idx       = ar_idx_q;
    m_aw_valid_o = 1'b0;
    m_ar_valid_o = 1'b0;
    wr_push_o    = 1'b0;
    rd_push_o    = 1'b0;
    case (state_q)
      remap_pkg::READY: begin
        // Reads and writes are admitted independently of each other
        if (ar_valid_i && ar_ok) begin
          ar_idx       = rd_exists_i ? rd_exists_idx_i : rd_free_i;
          m_ar_valid_o = 1'b1;
          rd_push_o    = 1'b1;
        end
        if (aw_valid_i && aw_ok) begin
          aw_idx       = wr_exists_i ? wr_exists_idx_i : wr_free_i;
          m_aw_valid_o = 1'b1;
          wr_push_o    = 1'b1;
        end
        // A stalled request is already in the table, so only its ID is kept
        if (m_ar_valid_o && !m_ar_ready_i) begin
          ar_idx_d = ar_idx;
        end
        if (m_aw_valid_o && !m_aw_ready_i) begin
          aw_idx_d = aw_idx;
        end
        if (m_ar_valid_o && !m_ar_ready_i && m_aw_valid_o && !m_aw_ready_i) begin
          state_d = remap_pkg::HOLD_AX;
        end else if (m_ar_valid_o && !m_ar_ready_i) begin
          state_d = remap_pkg::HOLD_AR;
        end else if (m_aw_valid_o && !m_aw_ready_i) begin
          state_d = remap_pkg::HOLD_AW;
        end
      end
      remap_pkg::HOLD_AR: begin
        m_ar_valid_o = 1'b1;
        if (m_ar_ready_i) begin
          state_d = remap_pkg::READY;
        end
      end
      remap_pkg::HOLD_AW: begin
        m_aw_valid_o = 1'b1;
        if (m_aw_ready_i) begin
          state_d = remap_pkg::READY;
        end
      end
      default: begin
        m_ar_valid_o = 1'b1;
        m_aw_valid_o = 1'b1;
        if (m_ar_ready_i && m_aw_ready_i) begin
          state_d = remap_pkg::READY;
        end else if (m_ar_ready_i) begin
          state_d = remap_pkg::HOLD_AW;
        end else if (m_aw_ready_i) begin
          state_d = remap_pkg::HOLD_AR;
        end
      end
    endcase
  end

  // Upstream completes exactly when downstream does
  assign aw_ready_o    = m_aw_valid_o && m_aw_ready_i;
  assign ar_ready_o    = m_ar_valid_o && m_ar_ready_i;
  assign wr_push_idx_o = aw_idx;
  assign rd_push_idx_o = ar_idx;
  assign m_aw_id_o     = axi_chan_pkg::id_out_t'(aw_idx);
  assign m_ar_id_o     = axi_chan_pkg::id_out_t'(ar_idx);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= remap_pkg::READY;
      aw_idx_q <= '0;
      ar_idx_q <= '0;
    end else begin
      state_q  <= state_d;
      aw_idx_q <= aw_idx_d;
      ar_idx_q <= ar_idx_d;
    end
  end

  // The held output ID must keep pointing at the entry pushed for this input ID
  a_aw_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_aw_valid_o && !m_aw_ready_i |=>
        m_aw_valid_o && $stable(m_aw_id_o) && $stable(aw_id_i))
    else $error("stalled AW changed its ID or dropped valid");

  a_ar_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_ar_valid_o && !m_ar_ready_i |=>
        m_ar_valid_o && $stable(m_ar_id_o) && $stable(ar_id_i))
    else $error("stalled AR changed its ID or dropped valid");

  // A downstream handshake is only legal while the master still presents its request
  a_aw_hs: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_aw_valid_o && m_aw_ready_i |-> aw_valid_i)
    else $error("downstream AW handshake without an upstream request");

  a_ar_hs: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_ar_valid_o && m_ar_ready_i |-> ar_valid_i)
    else $error("downstream AR handshake without an upstream request");

endmodule

`default_nettype wire

// ==== source/axi_id_remap.sv ====
// AXI ID remapper top level
`timescale 1ns/10ps
`default_nettype none
`include "idremap_consts.svh"

module axi_id_remap (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      aw_valid_i,
  input  wire axi_chan_pkg::id_in_t      aw_id_i,
  input  wire axi_chan_pkg::ax_payload_t aw_payload_i,
  output logic                           aw_ready_o,
  input  wire logic                      ar_valid_i,
  input  wire axi_chan_pkg::id_in_t      ar_id_i,
  input  wire axi_chan_pkg::ax_payload_t ar_payload_i,
  output logic                           ar_ready_o,
  input  wire logic                      w_valid_i,
  input  wire axi_chan_pkg::w_beat_t     w_beat_i,
  output logic                           w_ready_o,
  output logic                           b_valid_o,
  output axi_chan_pkg::id_in_t           b_id_o,
  output axi_chan_pkg::b_payload_t       b_payload_o,
  input  wire logic                      b_ready_i,
  output logic                           r_valid_o,
  output axi_chan_pkg::id_in_t           r_id_o,
  output axi_chan_pkg::r_beat_t          r_beat_o,
  input  wire logic                      r_ready_i,
  output logic                           m_aw_valid_o,
  output axi_chan_pkg::id_out_t          m_aw_id_o,
  output axi_chan_pkg::ax_payload_t      m_aw_payload_o,
  input  wire logic                      m_aw_ready_i,
  output logic                           m_ar_valid_o,
  output axi_chan_pkg::id_out_t          m_ar_id_o,
  output axi_chan_pkg::ax_payload_t      m_ar_payload_o,
  input  wire logic                      m_ar_ready_i,
  output logic                           m_w_valid_o,
  output axi_chan_pkg::w_beat_t          m_w_beat_o,
  input  wire logic                      m_w_ready_i,
  input  wire logic                      m_b_valid_i,
  input  wire axi_chan_pkg::id_out_t     m_b_id_i,
  input  wire axi_chan_pkg::b_payload_t  m_b_payload_i,
  output logic                           m_b_ready_o,
  input  wire logic                      m_r_valid_i,
  input  wire axi_chan_pkg::id_out_t     m_r_id_i,
  input  wire axi_chan_pkg::r_beat_t     m_r_beat_i,
  output logic                           m_r_ready_o
);

  remap_pkg::idx_t wr_free, wr_exists_idx, wr_push_idx, wr_pop_idx;
  remap_pkg::idx_t rd_free, rd_exists_idx, rd_push_idx, rd_pop_idx;
  logic            wr_full, wr_exists, wr_exists_full, wr_push, wr_pop;
  logic            rd_full, rd_exists, rd_exists_full, rd_push, rd_pop;

  // Only the IDs are touched, everything else goes straight through
  assign m_aw_payload_o = aw_payload_i;
  assign m_ar_payload_o = ar_payload_i;
  assign m_w_valid_o    = w_valid_i;
  assign m_w_beat_o     = w_beat_i;
  assign w_ready_o      = m_w_ready_i;
  assign b_valid_o      = m_b_valid_i;
  assign b_payload_o    = m_b_payload_i;
  assign m_b_ready_o    = b_ready_i;
  assign r_valid_o      = m_r_valid_i;
  assign r_beat_o       = m_r_beat_i;
  assign m_r_ready_o    = r_ready_i;

  // Every B ends a write burst, only the last R beat ends a read burst
  assign wr_pop     = m_b_valid_i && b_ready_i;
  assign rd_pop     = m_r_valid_i && r_ready_i && m_r_beat_i.last;
  assign wr_pop_idx = m_b_id_i[`IDX_WIDTH-1:0];
  assign rd_pop_idx = m_r_id_i[`IDX_WIDTH-1:0];

  remap_table wr_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (aw_id_i),
    .push_i        (wr_push),
    .push_idx_i    (wr_push_idx),
    .push_id_i     (aw_id_i),
    .pop_i         (wr_pop),
    .pop_idx_i     (wr_pop_idx),
    .free_o        (wr_free),
    .full_o        (wr_full),
    .exists_o      (wr_exists),
    .exists_idx_o  (wr_exists_idx),
    .exists_full_o (wr_exists_full),
    .pop_id_o      (b_id_o)
  );

  remap_table rd_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (ar_id_i),
    .push_i        (rd_push),
    .push_idx_i    (rd_push_idx),
    .push_id_i     (ar_id_i),
    .pop_i         (rd_pop),
    .pop_idx_i     (rd_pop_idx),
    .free_o        (rd_free),
    .full_o        (rd_full),
    .exists_o      (rd_exists),
    .exists_idx_o  (rd_exists_idx),
    .exists_full_o (rd_exists_full),
    .pop_id_o      (r_id_o)
  );

  id_remap_ctrl ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .aw_valid_i       (aw_valid_i),
    .aw_id_i          (aw_id_i),
    .ar_valid_i       (ar_valid_i),
    .ar_id_i          (ar_id_i),
    .m_aw_ready_i     (m_aw_ready_i),
    .m_ar_ready_i     (m_ar_ready_i),
    .wr_free_i        (wr_free),
    .wr_full_i        (wr_full),
    .wr_exists_i      (wr_exists),
    .wr_exists_idx_i  (wr_exists_idx),
    .wr_exists_full_i (wr_exists_full),
    .rd_free_i        (rd_free),
    .rd_full_i        (rd_full),
    .rd_exists_i      (rd_exists),
    .rd_exists_idx_i  (rd_exists_idx),
    .rd_exists_full_i (rd_exists_full),
    .aw_ready_o       (aw_ready_o),
    .ar_ready_o       (ar_ready_o),
    .m_aw_valid_o     (m_aw_valid_o),
    .m_ar_valid_o     (m_ar_valid_o),
    .m_aw_id_o        (m_aw_id_o),
    .m_ar_id_o        (m_ar_id_o),
    .wr_push_o        (wr_push),
    .wr_push_idx_o    (wr_push_idx),
    .rd_push_o        (rd_push),
    .rd_push_idx_o    (rd_push_idx)
  );

endmodule

`default_nettype wire

// ==== dv/tb_axi_id_remap.sv ====
// AXI ID remapper testbench
`timescale 1ns/10ps
`default_nettype none

module tb_axi_id_remap;

  localparam int TIMEOUT_CYCLES = 50;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      aw_valid_i, ar_valid_i, w_valid_i;
  axi_chan_pkg::id_in_t      aw_id_i, ar_id_i;
  axi_chan_pkg::ax_payload_t aw_payload_i, ar_payload_i;
  axi_chan_pkg::w_beat_t     w_beat_i;
  logic                      aw_ready_o, ar_ready_o, w_ready_o;
  logic                      b_valid_o, r_valid_o, b_ready_i, r_ready_i;
  axi_chan_pkg::id_in_t      b_id_o, r_id_o;
  axi_chan_pkg::b_payload_t  b_payload_o;
  axi_chan_pkg::r_beat_t     r_beat_o;
  logic                      m_aw_valid_o, m_ar_valid_o, m_w_valid_o;
  logic                      m_aw_ready_i, m_ar_ready_i, m_w_ready_i;
  axi_chan_pkg::id_out_t     m_aw_id_o, m_ar_id_o, m_b_id_i, m_r_id_i;
  axi_chan_pkg::ax_payload_t m_aw_payload_o, m_ar_payload_o;
  axi_chan_pkg::w_beat_t     m_w_beat_o;
  logic                      m_b_valid_i, m_r_valid_i, m_b_ready_o, m_r_ready_o;
  axi_chan_pkg::b_payload_t  m_b_payload_i;
  axi_chan_pkg::r_beat_t     m_r_beat_i;

  string  test_name;
  int     test_errors;
  int     total_errors;
  logic   timed_out;
  integer seed;

  axi_id_remap dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    test_errors++;
    total_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Test %s went wrong: %s", test_name, what);
    test_errors++;
    total_errors++;
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout in test %s while waiting for %s", test_name, what);
    timed_out = 1'b1;
    test_errors++;
    total_errors++;
  endtask

  function automatic logic down_valid(input logic is_read);
    return is_read ? m_ar_valid_o : m_aw_valid_o;
  endfunction

  function automatic axi_chan_pkg::id_out_t down_id(input logic is_read);
    return is_read ? m_ar_id_o : m_aw_id_o;
  endfunction

  function automatic axi_chan_pkg::ax_payload_t down_payload(input logic is_read);
    return is_read ? m_ar_payload_o : m_aw_payload_o;
  endfunction

  function automatic logic up_ready(input logic is_read);
    return is_read ? ar_ready_o : aw_ready_o;
  endfunction

  task automatic drive_request(input logic is_read, input logic valid,
                               input axi_chan_pkg::id_in_t id,
                               input axi_chan_pkg::ax_payload_t payload);
    if (is_read) begin
      ar_valid_i   = valid;
      ar_id_i      = id;
      ar_payload_i = payload;
    end else begin
      aw_valid_i   = valid;
      aw_id_i      = id;
      aw_payload_i = payload;
    end
  endtask

  task automatic drive_down_ready(input logic is_read, input logic ready);
    if (is_read) begin
      m_ar_ready_i = ready;
    end else begin
      m_aw_ready_i = ready;
    end
  endtask

  // W has no ID, so the beat and both handshake signals pass straight through
  task automatic check_w_beat(input axi_chan_pkg::w_beat_t beat, input logic ready);
    w_valid_i   = 1'b1;
    w_beat_i    = beat;
    m_w_ready_i = ready;
    @(negedge clk_i);
    if (!m_w_valid_o) begin
      report_failure("W valid did not pass through");
    end
    if (m_w_beat_o.data !== beat.data) begin
      report_mismatch("W data", beat.data, m_w_beat_o.data);
    end
    if (m_w_beat_o.strb !== beat.strb || m_w_beat_o.last !== beat.last) begin
      report_mismatch("W strb and last", 32'({beat.strb, beat.last}),
                      32'({m_w_beat_o.strb, m_w_beat_o.last}));
    end
    if (w_ready_o !== ready) begin
      report_mismatch("W ready", 32'(ready), 32'(w_ready_o));
    end
    @(posedge clk_i);
    #1;
    w_valid_i   = 1'b0;
    m_w_ready_i = 1'b0;
  endtask

  // One AW or AR burst from upstream, with the downstream slave stalling for a while
  task automatic run_request(input logic is_read, input axi_chan_pkg::id_in_t id,
                             input axi_chan_pkg::ax_payload_t payload, input int delay,
                             input axi_chan_pkg::id_out_t exp_id);
    int                        cycles;
    int                        stall;
    int                        k;
    axi_chan_pkg::id_out_t     first_id;
    axi_chan_pkg::ax_payload_t seen;
    stall = delay;
    if (delay < 0) begin
      stall = $random(seed) & 3;
    end
    drive_request(is_read, 1'b1, id, payload);
    drive_down_ready(is_read, stall == 0);
    cycles = 0;
    @(negedge clk_i);
    while (!down_valid(is_read) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!down_valid(is_read)) begin
      note_timeout("the downstream request");
    end else begin
      first_id = down_id(is_read);
      seen     = down_payload(is_read);
      if (first_id !== exp_id) begin
        report_mismatch("output ID", 32'(exp_id), 32'(first_id));
      end
      if (seen.addr !== payload.addr) begin
        report_mismatch("address", 32'(payload.addr), 32'(seen.addr));
      end
      if (seen.len !== payload.len) begin
        report_mismatch("len", 32'(payload.len), 32'(seen.len));
      end
      // While ready is low the request must sit still with its ID
      for (k = 0; k < stall; k++) begin
        if (!down_valid(is_read) || up_ready(is_read) || down_id(is_read) !== first_id) begin
          report_failure("stalled request dropped valid, changed ID or was accepted");
        end
        @(posedge clk_i);
        #1;
        if (k == stall - 1) begin
          drive_down_ready(is_read, 1'b1);
        end
        @(negedge clk_i);
      end
      if (!down_valid(is_read) || !up_ready(is_read)) begin
        report_failure("no handshake after downstream ready rose");
      end
      if (stall > 0 && down_id(is_read) !== first_id) begin
        report_mismatch("held output ID", 32'(first_id), 32'(down_id(is_read)));
      end
      @(posedge clk_i);
      #1;
      drive_request(is_read, 1'b0, id, payload);
      drive_down_ready(is_read, 1'b0);
      @(negedge clk_i);
      if (down_valid(is_read)) begin
        report_failure("a second downstream request followed the handshake");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  // The request stays valid afterwards so that a later line can complete it
  task automatic check_blocked(input logic is_read, input axi_chan_pkg::id_in_t id,
                               input axi_chan_pkg::ax_payload_t payload, input int cycles);
    int k;
    drive_request(is_read, 1'b1, id, payload);
    drive_down_ready(is_read, 1'b0);
    for (k = 0; k < cycles; k++) begin
      @(negedge clk_i);
      if (down_valid(is_read) || up_ready(is_read)) begin
        report_failure("request went through although every output ID is in use");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_response(input logic is_read, input axi_chan_pkg::id_out_t out_id,
                              input logic [31:0] data, input logic [1:0] resp,
                              input logic last, input axi_chan_pkg::id_in_t exp_id);
    if (is_read) begin
      m_r_valid_i     = 1'b1;
      m_r_id_i        = out_id;
      m_r_beat_i.data = data;
      m_r_beat_i.resp = axi_chan_pkg::resp_e'(resp);
      m_r_beat_i.last = last;
      r_ready_i       = 1'b1;
    end else begin
      m_b_valid_i        = 1'b1;
      m_b_id_i           = out_id;
      m_b_payload_i.resp = axi_chan_pkg::resp_e'(resp);
      b_ready_i          = 1'b1;
    end
    @(negedge clk_i);
    if (is_read) begin
      if (!r_valid_o || !m_r_ready_o) begin
        report_failure("R handshake did not pass through");
      end
      if (r_id_o !== exp_id) begin
        report_mismatch("restored R ID", 32'(exp_id), 32'(r_id_o));
      end
      if (r_beat_o.data !== data) begin
        report_mismatch("R data", data, r_beat_o.data);
      end
      if (2'(r_beat_o.resp) !== resp || r_beat_o.last !== last) begin
        report_mismatch("R resp and last", 32'({resp, last}), 32'({r_beat_o.resp, r_beat_o.last}));
      end
    end else begin
      if (!b_valid_o || !m_b_ready_o) begin
        report_failure("B handshake did not pass through");
      end
      if (b_id_o !== exp_id) begin
        report_mismatch("restored B ID", 32'(exp_id), 32'(b_id_o));
      end
      if (2'(b_payload_o.resp) !== resp) begin
        report_mismatch("B resp", 32'(resp), 32'(b_payload_o.resp));
      end
    end
    @(posedge clk_i);
    #1;
    m_r_valid_i = 1'b0;
    m_b_valid_i = 1'b0;
    r_ready_i   = 1'b0;
    b_ready_i   = 1'b0;
  endtask

  initial begin
    int                        fd;
    int                        n;
    int                        dly_f;
    int                        tests;
    int                        failed_tests;
    string                     line;
    string                     name_f;
    string                     op_f;
    logic [31:0]               id_f, val_f, len_f, exp_f, last_f;
    axi_chan_pkg::ax_payload_t pl;
    axi_chan_pkg::w_beat_t     wb;
    seed         = 98;
    total_errors = 0;
    test_errors  = 0;
    timed_out    = 1'b0;
    tests        = 0;
    failed_tests = 0;
    rst_ni       = 1'b0;
    aw_valid_i   = 1'b0;
    aw_id_i      = '0;
    aw_payload_i = '0;
    ar_valid_i   = 1'b0;
    ar_id_i      = '0;
    ar_payload_i = '0;
    w_valid_i    = 1'b0;
    w_beat_i     = '0;
    b_ready_i    = 1'b0;
    r_ready_i    = 1'b0;
    m_aw_ready_i = 1'b0;
    m_ar_ready_i = 1'b0;
    m_w_ready_i  = 1'b0;
    m_b_valid_i  = 1'b0;
    m_b_id_i     = '0;
    m_b_payload_i = '0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_beat_i   = '0;
    fd = $fopen("dv/axi_remap_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file dv/axi_remap_testdata.txt");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      repeat (2) @(posedge clk_i);
      #1;
      rst_ni    = 1'b1;
      test_name = "reset_idle";
      @(negedge clk_i);
      if (m_aw_valid_o || m_ar_valid_o || aw_ready_o || ar_ready_o) begin
        report_failure("request valid or ready is high after reset");
      end
      tests++;
      $display("test %s: %s", test_name, (test_errors == 0) ? "passed" : "failed");
      failed_tests += (test_errors != 0);
      @(posedge clk_i);
      #1;
      test_errors = 0;
      test_name   = "w_passthrough";
      wb.data     = 32'h13579bdf;
      wb.strb     = 4'hf;
      wb.last     = 1'b0;
      check_w_beat(wb, 1'b1);
      wb.data     = 32'h2468ace0;
      wb.strb     = 4'h5;
      wb.last     = 1'b1;
      check_w_beat(wb, 1'b0);
      tests++;
      $display("test %s: %s", test_name, (test_errors == 0) ? "passed" : "failed");
      failed_tests += (test_errors != 0);
      while (!$feof(fd) && !timed_out) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
          test_errors = 0;
          n = $sscanf(line, "%s %s %h %h %h %d %h %h", name_f, op_f, id_f, val_f, len_f,
                      dly_f, exp_f, last_f);
          test_name = name_f;
          pl.addr   = val_f[15:0];
          pl.len    = len_f[7:0];
          if (n != 8) begin
            report_failure("malformed test data line");
          end else if (op_f == "AW" || op_f == "AR") begin
            run_request(op_f == "AR", axi_chan_pkg::id_in_t'(id_f), pl, dly_f,
                        axi_chan_pkg::id_out_t'(exp_f));
          end else if (op_f == "AWBLK" || op_f == "ARBLK") begin
            check_blocked(op_f == "ARBLK", axi_chan_pkg::id_in_t'(id_f), pl, dly_f);
          end else if (op_f == "B" || op_f == "R") begin
            run_response(op_f == "R", axi_chan_pkg::id_out_t'(id_f), val_f, len_f[1:0],
                         last_f[0], axi_chan_pkg::id_in_t'(exp_f));
          end else begin
            report_failure("unknown operation in the test data");
          end
          tests++;
          $display("test %s: %s", test_name, (test_errors == 0) ? "passed" : "failed");
          failed_tests += (test_errors != 0);
        end
      end
      $fclose(fd);
      $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed_tests,
               total_errors);
      if (total_errors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== idremap.f ====
+incdir+source
source/axi_chan_pkg.sv
source/remap_pkg.sv
source/remap_table.sv
source/id_remap_ctrl.sv
source/axi_id_remap.sv
dv/tb_axi_id_remap.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI ID remapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

if ! rm -rf "$BUILD_DIR"; then
  echo "Could not clean $BUILD_DIR"
  exit 1
fi

if ! verilator --binary --timing --assert -Mdir "$BUILD_DIR" \
    --top-module tb_axi_id_remap -o sim_tb -f idremap.f; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi
echo "Simulation passed"
exit 0

// ==== dv/axi_remap_testdata.txt ====
# name op id(hex) val(hex) len(hex) delay(dec, -1 is random) expected_id(hex) last
# AW/AR: id is the input ID, val the address. B/R: id is the output ID, len the resp, val R data
aw_new0     AW    5 1000     00  0 0 0
aw_new1     AW    9 1010     03  1 1 0
aw_same0    AW    5 1020     01  0 0 0
aw_new2     AW    3 2000     07 -1 2 0
aw_new3     AW    c 3000     00  0 3 0
aw_full     AWBLK 7 4000     02  4 0 0
b_out2      B     2 0        0   0 3 0
aw_freed    AW    7 4000     02  2 2 0
aw_stall    AW    9 5000     0f  3 1 0
b_out0a     B     0 0        1   0 5 0
b_out0b     B     0 0        0   0 5 0
b_out1a     B     1 0        2   0 9 0
b_out1b     B     1 0        0   0 9 0
b_out2b     B     2 0        3   0 7 0
b_out3      B     3 0        1   0 c 0
aw_reuse0   AW    a 6000     01  0 0 0
b_reuse0    B     0 0        2   0 a 0
ar_new0     AR    5 0100     00  0 0 0
ar_new1     AR    2 0200     01  1 1 0
r_part0     R     0 deadbeef 0   0 5 0
ar_new2     AR    b 0300     03  0 2 0
ar_new3     AR    6 0400     00 -1 3 0
r_last0     R     0 12345678 1   0 5 1
ar_reuse0   AR    e 0500     00  0 0 0
ar_same1    AR    2 0600     07  2 1 0
r_last1a    R     1 cafe0001 0   0 2 1
r_last1b    R     1 cafe0002 2   0 2 1
r_last0b    R     0 0000ffff 3   0 e 1
r_last2     R     2 a5a5a5a5 0   0 b 1
r_last3     R     3 5a5a5a5a 1   0 6 1
